/* colorRamSys.f */
hw/videoPkg.sv
hw/cpuBusPkg.sv
hw/paletteIndexMux.sv
hw/colorRam.sv
hw/colorOutput.sv
hw/colorRamSys.sv
tb/colorRamSysTb.sv

/* Makefile */
TOP = colorRamSysTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f colorRamSys.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only --timing --assert --top-module colorRamSys -f colorRamSys.f

clean:
	rm -rf obj_dir

/* tb/colorRamSysTb.sv */
`timescale 1ns/10ps

module colorRamSysTb import videoPkg::*, cpuBusPkg::*; ();

    localparam int resetCycles  = 16;
    localparam int fillCycles   = 1024;
    localparam int readCycles   = 64;
    localparam int streamCycles = 200;
    localparam int mixCycles    = 300;
    localparam int rawPairs     = 4;
    localparam int holdCycles   = 8;
    localparam int drainCycles  = 4;
    localparam int totalCycles  = resetCycles + fillCycles + readCycles + 4 * streamCycles
                                  + mixCycles + rawPairs * (2 + holdCycles) + drainCycles;
    localparam int watchdogNs   = totalCycles * 20 + 2000;    // 100 cycles of margin

    logic    mckf = 1'b0;
    logic    arstN;
    mpxT     mpx;
    pfxT     pfx;
    alcT     alc;
    apixT    apix;
    gctT     gct;
    bankT    cras;
    cpuAddrT ma;
    cpuDataT vbdIn;
    logic    cramN;
    logic    cramWrN;
    logic    brW;
    colorT   colorOut;
    cpuDataT vbdOut;

    logic [15:0] shadow [0:1023];   // Palette as the CPU wrote it
    logic [31:0] lcgState;
    string       testName;
    int          seqFails = 0;      // Failed checks in the stimulus sequence
    int          modelFails = 0;    // Failed checks in the compare process
    int          testErrStart;
    int          testCount;
    int          failCount;

    // Expected register contents after the last clock edge
    logic [9:0]  mAddr = '0;        // Bank and index register
    logic [15:0] mRam = '0;
    logic        mValid = 1'b0;
    logic [15:0] mColor = '0;
    logic [15:0] mVbd = '0;

    colorRamSys u_colorRamSys (
        .mckf     (mckf),
        .arstN    (arstN),
        .mpx      (mpx),
        .pfx      (pfx),
        .alc      (alc),
        .apix     (apix),
        .gct      (gct),
        .cras     (cras),
        .ma       (ma),
        .vbdIn    (vbdIn),
        .cramN    (cramN),
        .cramWrN  (cramWrN),
        .brW      (brW),
        .colorOut (colorOut),
        .vbdOut   (vbdOut)
    );

    always #10 mckf = ~mckf;        // 20 ns master clock

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Expected RAM address of one pixel, bank above the index
    function automatic logic [9:0] refAddress(
        input logic [1:0] g,
        input logic [6:0] m,
        input logic [7:0] p,
        input logic [2:0] a,
        input logic [1:0] ap,
        input logic [1:0] bank
    );
        logic [7:0] idx;
        case (g)
            2'd3: idx = {3'b000, a, ap};            // Alphanumerics
            2'd2: idx = {1'b0, ~m};                 // Motion code arrives inverted
            2'd1: idx = p;                          // Playfield
            default: idx = {p[3:0], ~m[3:0]};       // Mixed
        endcase
        return {bank, idx};
    endfunction

    task automatic checkValue(input string what, input logic [15:0] expVal,
                              input logic [15:0] actVal, output bit bad);
        bad = (actVal !== expVal);
        if (bad) begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expVal, actVal);
        end
    endtask

    task automatic startTest(input string name);
        testName     = name;
        testErrStart = seqFails + modelFails;
    endtask

    task automatic endTest();
        int newErrs;
        newErrs = seqFails + modelFails - testErrStart;
        testCount++;
        if (newErrs == 0) begin
            $display("test %s passed", testName);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", testName, newErrs);
        end
    endtask

    // Inputs change 2 ns after the edge and stay for one clock
    task automatic waitCycle();
        @(posedge mckf);
        #2;
    endtask

    task automatic driveVideo(
        input logic [1:0] g,
        input logic [6:0] m,
        input logic [7:0] p,
        input logic [2:0] a,
        input logic [1:0] ap,
        input logic [1:0] bank
    );
        cramN   = 1'b1;
        cramWrN = 1'b1;
        brW     = 1'b1;
        gct     = g;
        mpx     = m;
        pfx     = p;
        alc     = a;
        apix    = ap;
        cras    = bank;
        waitCycle();
    endtask

    task automatic driveRandomVideo(input logic [1:0] g);
        logic [31:0] r;
        r = nextRand();
        driveVideo(g, r[22:16], r[31:24], r[13:11], r[10:9], r[15:14]);
    endtask

    task automatic driveWrite(input logic [9:0] addr, input logic [15:0] data);
        cramN   = 1'b0;
        cramWrN = 1'b0;
        brW     = 1'b0;
        ma      = addr;
        vbdIn   = data;
        waitCycle();
    endtask

    task automatic driveRead(input logic [9:0] addr);
        cramN   = 1'b0;
        cramWrN = 1'b1;
        brW     = 1'b1;
        ma      = addr;
        waitCycle();
    endtask

    // Checks between edges, then steps the expected registers through the coming edge
    always @(negedge mckf) begin : compare
        logic [15:0] heldColor;
        bit          bad;
        if (arstN) begin
            checkValue("colorOut", mColor, colorOut, bad);
            modelFails += int'(bad);
            checkValue("vbdOut", mVbd, vbdOut, bad);
            modelFails += int'(bad);
            heldColor = mValid ? mRam : mColor;     // Output stage holds on steal
            if (cramN) begin
                mRam = shadow[mAddr];               // Video lookup
            end
            mValid = cramN;
            if (!cramN && brW) begin
                mVbd = shadow[ma];
            end
            if (!cramN && !cramWrN && !brW) begin
                shadow[ma] = vbdIn;
            end
            mColor = heldColor;
            mAddr  = refAddress(gct, mpx, pfx, alc, apix, cras);
        end
    end

    initial begin : watchdog
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : mainSeq
        logic [31:0] r;
        logic [31:0] d;
        logic [9:0]  addr;
        logic [9:0]  lookAddr;
        logic        pending;
        bit          bad;
        arstN    = 1'b0;
        mpx      = '0;
        pfx      = '0;
        alc      = '0;
        apix     = '0;
        gct      = gctMixed;
        cras     = '0;
        ma       = '0;
        vbdIn    = '0;
        cramN    = 1'b1;
        cramWrN  = 1'b1;
        brW      = 1'b1;
        lcgState = 32'h21eedc3b;
        lookAddr = '0;
        repeat (resetCycles) @(posedge mckf);
        #2;
        arstN = 1'b1;

        startTest("reset");
        checkValue("colorOut", 16'h0000, colorOut, bad);
        seqFails += int'(bad);
        checkValue("vbdOut", 16'h0000, vbdOut, bad);
        seqFails += int'(bad);
        endTest();

        // Palette is filled before any video cycle reaches the RAM
        startTest("fill");
        for (int i = 0; i < fillCycles; i++) begin
            r = nextRand();
            driveWrite(10'(i), r[31:16]);
        end
        for (int i = 0; i < readCycles; i++) begin
            r    = nextRand();
            addr = r[25:16];
            driveRead(addr);
            checkValue("readback", shadow[addr], vbdOut, bad);
            seqFails += int'(bad);
        end
        endTest();

        for (int g = 0; g < 4; g++) begin
            startTest($sformatf("stream%0d", g));
            repeat (streamCycles) begin
                driveRandomVideo(2'(g));
            end
            endTest();
        end

        startTest("steal");
        pending = 1'b0;
        repeat (mixCycles) begin
            r = nextRand();
            if (r[30:28] == 3'd0) begin
                d        = nextRand();
                lookAddr = r[25:16];
                driveWrite(lookAddr, d[31:16]);
                pending = 1'b1;
            end else if (pending) begin
                // Playfield mode reaches any entry of a bank directly
                driveVideo(gctPlayfield, r[22:16], lookAddr[7:0], r[13:11], r[10:9],
                           lookAddr[9:8]);
                pending = 1'b0;
            end else begin
                driveRandomVideo(r[27:26]);
            end
        end
        endTest();

        startTest("readAfterWrite");
        repeat (rawPairs) begin
            r    = nextRand();
            d    = nextRand();
            addr = r[25:16];
            driveWrite(addr, d[31:16]);
            driveRead(addr);
            checkValue("readback", d[31:16], vbdOut, bad);
            seqFails += int'(bad);
            repeat (holdCycles) begin
                driveRandomVideo(r[1:0]);
            end
            checkValue("vbdOut hold", d[31:16], vbdOut, bad);
            seqFails += int'(bad);
        end
        repeat (drainCycles) begin
            driveRandomVideo(gctMixed);         // Flush the last pixels to the output
        end
        endTest();

        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failCount,
                 seqFails + modelFails);
        if (seqFails + modelFails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hw/colorRamSys.sv */
`timescale 1ns/10ps

module colorRamSys import videoPkg::*, cpuBusPkg::*; (
    input  logic    mckf,       // Master clock from sync generator
    input  logic    arstN,
    input  mpxT     mpx,        // Motion object line buffer
    input  pfxT     pfx,        // Playfield scroll
    input  alcT     alc,        // Alphanumerics
    input  apixT    apix,
    input  gctT     gct,        // Priority control
    input  bankT    cras,
    input  cpuAddrT ma,         // Host address
    input  cpuDataT vbdIn,
    input  logic    cramN,      // Address decoder select
    input  logic    cramWrN,
    input  logic    brW,
    output colorT   colorOut,   // Monitor color
    output cpuDataT vbdOut      // Host read data
);

    palIndexT pixIndex;
    bankT     pixBank;
    colorT    ramData;
    logic     videoValid;

    paletteIndexMux u_paletteIndexMux (
        .mckf     (mckf),
        .arstN    (arstN),
        .mpx      (mpx),
        .pfx      (pfx),
        .alc      (alc),
        .apix     (apix),
        .gct      (gct),
        .cras     (cras),
        .pixIndex (pixIndex),
        .pixBank  (pixBank)
    );

    colorRam u_colorRam (
        .mckf       (mckf),
        .arstN      (arstN),
        .pixIndex   (pixIndex),
        .pixBank    (pixBank),
        .ma         (ma),
        .vbdIn      (vbdIn),
        .cramN      (cramN),
        .cramWrN    (cramWrN),
        .brW        (brW),
        .ramData    (ramData),
        .vbdOut     (vbdOut),
        .videoValid (videoValid)
    );

    colorOutput u_colorOutput (
        .mckf       (mckf),
        .arstN      (arstN),
        .ramData    (ramData),
        .videoValid (videoValid),
        .colorOut   (colorOut)
    );

endmodule

/* hw/colorOutput.sv */
`timescale 1ns/10ps

module colorOutput import videoPkg::*; (
    input  logic  mckf,
    input  logic  arstN,
    input  colorT ramData,      // From the color RAM
    input  logic  videoValid,   // Low after a CPU cycle
    output colorT colorOut      // To the monitor interface
);

    colorT nextColor;

    // A stolen cycle repeats the last pixel instead of showing
    // whatever word the CPU touched
    assign nextColor = videoValid ? ramData : colorOut;

    always_ff @(posedge mckf or negedge arstN) begin
        if (!arstN) begin
            colorOut <= '0;
        end else begin
            colorOut <= nextColor;
        end
    end

endmodule

/* hw/colorRam.sv */
`timescale 1ns/10ps

module colorRam import videoPkg::*, cpuBusPkg::*; (
    input  logic     mckf,
    input  logic     arstN,
    input  palIndexT pixIndex,      // Registered palette index
    input  bankT     pixBank,
    input  cpuAddrT  ma,            // CPU word address
    input  cpuDataT  vbdIn,         // CPU write data
    input  logic     cramN,         // CPU owns the RAM when low
    input  logic     cramWrN,       // Write strobe
    input  logic     brW,           // High for a CPU read
    output colorT    ramData,       // Looked up color
    output cpuDataT  vbdOut,        // CPU read data
    output logic     videoValid     // ramData came from a video cycle
);

    colorT   colorMem [0:cpuWords-1];   // Four 1K x 4 parts on the board
    cpuAddrT ramAddr;
    colorT   rdWord;
    logic    cpuWr;
    logic    cpuRd;

    assign cpuWr = !cramN && !cramWrN && !brW;
    assign cpuRd = !cramN && brW;

    // CPU wins the address buffer whenever it selects the RAM
    assign ramAddr = !cramN ? ma : {pixBank, pixIndex};
    assign rdWord  = colorMem[ramAddr];

    always_ff @(posedge mckf) begin
        if (cpuWr) begin
            colorMem[ramAddr] <= vbdIn;
        end
    end

    // Synchronous read for the video side
    always_ff @(posedge mckf or negedge arstN) begin
        if (!arstN) begin
            ramData    <= '0;
            videoValid <= 1'b0;
        end else begin
            ramData    <= rdWord;
            videoValid <= cramN;        // Low marks a stolen cycle
        end
    end

    // CPU read latch keeps its word until the next read
    always_ff @(posedge mckf or negedge arstN) begin
        if (!arstN) begin
            vbdOut <= '0;
        end else if (cpuRd) begin
            vbdOut <= rdWord;
        end
    end

    // Write strobe is only decoded inside a color RAM select
    wrNeedsSelect: assert property (
        @(posedge mckf) disable iff (!arstN)
        !cramWrN |-> !cramN
    ) else $error("cramWrN low without cramN");

    // Bus direction must agree with the write strobe
    wrNeedsWriteDir: assert property (
        @(posedge mckf) disable iff (!arstN)
        (!cramN && !cramWrN) |-> !brW
    ) else $error("Write strobe during a read cycle");

endmodule

/* hw/paletteIndexMux.sv */
`timescale 1ns/10ps

module paletteIndexMux import videoPkg::*; (
    input  logic     mckf,      // Master clock
    input  logic     arstN,
    input  mpxT      mpx,       // From motion object line buffer
    input  pfxT      pfx,       // From playfield scroll
    input  alcT      alc,       // From alphanumerics
    input  apixT     apix,
    input  gctT      gct,       // From priority control
    input  bankT     cras,      // Palette bank
    output palIndexT pixIndex,
    output bankT     pixBank
);

    mpxT      mpxInv;           // Motion code leaves the buffer inverted
    palIndexT nextIndex;

    assign mpxInv = ~mpx;

    // Stands in for the four dual 4-to-1 selectors of the board
    always_comb begin
        case (gct)
            gctAlpha: begin
                nextIndex = {3'b000, alc, apix};    // Low 32 entries of bank
            end
            gctMotion: begin
                nextIndex = {1'b0, mpxInv};         // Lower half of bank
            end
            gctPlayfield: begin
                nextIndex = pfx;
            end
            default: begin
                // Mixed mode takes the playfield color group and the
                // motion object pixel bits
                nextIndex = {pfx[3:0], mpxInv[3:0]};
            end
        endcase
    end

    // Index and bank are latched together so the RAM sees one
    // coherent address per pixel
    always_ff @(posedge mckf or negedge arstN) begin
        if (!arstN) begin
            pixIndex <= '0;
            pixBank  <= '0;
        end else begin
            pixIndex <= nextIndex;
            pixBank  <= cras;
        end
    end

endmodule

/* hw/cpuBusPkg.sv */
package cpuBusPkg;

    // Host side of the color RAM

    typedef logic [9:0] cpuAddrT;   // Word address, ma on the board
    typedef logic [15:0] cpuDataT;  // Split data bus word

    // Number of words the CPU can reach
    localparam int cpuWords = 2 ** $bits(cpuAddrT);

    // Strobes are active low and sampled on the master clock
    // cramN   selects the color RAM
    // cramWrN write strobe
    // brW     bus direction, high for read

endpackage

/* hw/videoPkg.sv */
package videoPkg;

    // Pixel source codes as they arrive from the video sources
    typedef logic [6:0] mpxT;       // Motion object pixel code
    typedef logic [7:0] pfxT;       // Playfield pixel code
    typedef logic [2:0] alcT;       // Alphanumeric color
    typedef logic [1:0] apixT;      // Alphanumeric pixel

    // Priority control outputs
    typedef logic [1:0] gctT;       // Source select from priority logic
    typedef logic [1:0] bankT;      // Palette bank, cras on the board

    // Priority source codes
    localparam gctT gctMixed     = 2'd0;   // Playfield color, motion pixel
    localparam gctT gctPlayfield = 2'd1;
    localparam gctT gctMotion    = 2'd2;
    localparam gctT gctAlpha     = 2'd3;

    // Lookup side
    typedef logic [7:0] palIndexT;  // Entry within one bank
    typedef logic [15:0] colorT;    // Word sent to the monitor

    // Bank and index together form the color RAM address, so the
    // pair has to stay as wide as the CPU word address
    localparam int palAddrBits = $bits(bankT) + $bits(palIndexT);

endpackage
